// File: include/mlsd_config.svh
`ifndef MLSD_CONFIG_SVH
`define MLSD_CONFIG_SVH

// Frame geometry and arithmetic widths.
`define MLSD_LANES        8
`define MLSD_CODE_WIDTH   8
`define MLSD_TAP_WIDTH    8
`define MLSD_EST_DEPTH    4
`define MLSD_SEQ_LENGTH   3
`define MLSD_METRIC_WIDTH 14

// Frames of context needed around the centre frame.
`define MLSD_PAST_FRAMES   ((`MLSD_EST_DEPTH - 1 + `MLSD_LANES - 1) / `MLSD_LANES)
`define MLSD_FUTURE_FRAMES ((`MLSD_SEQ_LENGTH - 1 + `MLSD_LANES - 1) / `MLSD_LANES)
`define MLSD_FRAME_DEPTH   (`MLSD_PAST_FRAMES + `MLSD_FUTURE_FRAMES + 1)

`endif

// File: design/mlsdTypesPkg.sv
`include "mlsd_config.svh"

package mlsdTypesPkg;

	// Received ADC code, signed.
	typedef logic signed [`MLSD_CODE_WIDTH-1:0] codeT;

	// One tap of the channel estimate, signed.
	typedef logic signed [`MLSD_TAP_WIDTH-1:0] tapT;

	// A symbol is either +1 or -1.
	typedef logic signed [1:0] symbolT;

	// Sum of absolute errors over one hypothesis sequence.
	typedef logic [`MLSD_METRIC_WIDTH-1:0] metricT;

endpackage

// File: design/mlsdTapPkg.sv
`include "mlsd_config.svh"

package mlsdTapPkg;

	// Number of taps in the channel estimate.
	localparam int tapCount = `MLSD_EST_DEPTH;

	typedef logic [$clog2(tapCount)-1:0] tapAddrT;

endpackage

// File: design/mlsdTapStore.sv
`include "mlsd_config.svh"

module mlsdTapStore (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  tapWrite,
	input  mlsdTapPkg::tapAddrT   tapAddr,
	input  mlsdTypesPkg::tapT     tapData,
	output mlsdTypesPkg::tapT     taps [mlsdTapPkg::tapCount]
);

	import mlsdTapPkg::*;

	// ##########################################################
	// Estimate registers
	// ##########################################################

	// Tap k weighs the symbol k positions before the current one.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < tapCount; k++) begin
				taps[k] <= '0;
			end
		end else if (tapWrite) begin
			taps[tapAddr] <= tapData;
		end
	end

endmodule

// File: design/mlsdFrameBuffer.sv
`include "mlsd_config.svh"

module mlsdFrameBuffer (
	input  logic               clk,
	input  logic               arstN,
	input  logic               inValid,
	input  mlsdTypesPkg::codeT codes [`MLSD_LANES],
	input  logic               estimateBits [`MLSD_LANES],
	output mlsdTypesPkg::codeT windowCodes [`MLSD_FRAME_DEPTH * `MLSD_LANES],
	output logic               windowBits [`MLSD_FRAME_DEPTH * `MLSD_LANES],
	output logic               frameValid
);

	import mlsdTypesPkg::*;

	localparam int lanes      = `MLSD_LANES;
	localparam int depth      = `MLSD_FRAME_DEPTH;
	localparam int countWidth = $clog2(depth + 1);

	// Frame 0 is the oldest, frame depth-1 the one strobed last.
	codeT frameCodes [depth][lanes];
	logic frameBits  [depth][lanes];

	logic [countWidth-1:0] fillCount;

	// ##########################################################
	// Frame history
	// ##########################################################

	always_ff @(posedge clk) begin
		if (inValid) begin
			for (int f = 0; f < depth - 1; f++) begin
				frameCodes[f] <= frameCodes[f + 1];
				frameBits[f]  <= frameBits[f + 1];
			end
			frameCodes[depth - 1] <= codes;
			frameBits[depth - 1]  <= estimateBits;
		end
	end

	// A decision needs full past and future context, so nothing is
	// released until the history holds depth frames.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			fillCount  <= '0;
			frameValid <= 1'b0;
		end else begin
			if (inValid && fillCount != countWidth'(depth)) begin
				fillCount <= fillCount + 1'b1;
			end
			frameValid <= inValid && (fillCount >= countWidth'(depth - 1));
		end
	end

	// Lane l of frame f is serial symbol f*lanes + l.
	always_comb begin
		for (int f = 0; f < depth; f++) begin
			for (int l = 0; l < lanes; l++) begin
				windowCodes[f * lanes + l] = frameCodes[f][l];
				windowBits[f * lanes + l]  = frameBits[f][l];
			end
		end
	end

endmodule

// File: design/mlsdSeqEstimator.sv
`include "mlsd_config.svh"

module mlsdSeqEstimator (
	input  logic               clk,
	input  logic               arstN,
	input  logic               frameValid,
	input  mlsdTypesPkg::codeT windowCodes [`MLSD_FRAME_DEPTH * `MLSD_LANES],
	input  logic               windowBits [`MLSD_FRAME_DEPTH * `MLSD_LANES],
	input  mlsdTypesPkg::tapT  taps [`MLSD_EST_DEPTH],
	output mlsdTypesPkg::codeT hypSeq [2][`MLSD_LANES][`MLSD_SEQ_LENGTH],
	output mlsdTypesPkg::codeT rxSeq [`MLSD_LANES][`MLSD_SEQ_LENGTH],
	output logic               centreBits [`MLSD_LANES],
	output logic               seqValid
);

	import mlsdTypesPkg::*;

	localparam int lanes      = `MLSD_LANES;
	localparam int estDepth   = `MLSD_EST_DEPTH;
	localparam int seqLen     = `MLSD_SEQ_LENGTH;
	localparam int winLength  = `MLSD_FRAME_DEPTH * `MLSD_LANES;
	localparam int centreBase = `MLSD_PAST_FRAMES * `MLSD_LANES;
	localparam int sumWidth   = `MLSD_TAP_WIDTH + $clog2(estDepth) + 1;
	localparam int codeMax    = (1 << (`MLSD_CODE_WIDTH - 1)) - 1;
	localparam int codeMin    = -(1 << (`MLSD_CODE_WIDTH - 1));

	typedef logic signed [sumWidth-1:0] sumT;

	symbolT winSym [winLength];
	sumT    tapExt [estDepth];
	codeT   hypNext [2][lanes][seqLen];

	function automatic codeT saturate(input sumT value);
		if (value > codeMax) begin
			return codeT'(codeMax);
		end
		if (value < codeMin) begin
			return codeT'(codeMin);
		end
		return codeT'(value);
	endfunction

	always_comb begin
		for (int i = 0; i < winLength; i++) begin
			winSym[i] = windowBits[i] ? symbolT'(1) : symbolT'(-1);
		end
		for (int k = 0; k < estDepth; k++) begin
			tapExt[k] = sumT'(taps[k]);
		end
	end

	// ##########################################################
	// Hypothesis sequences
	// ##########################################################

	// Hypothesis 0 forces the centre symbol to -1, hypothesis 1 to +1.
	always_comb begin : buildSequences
		int     pos;
		int     centre;
		sumT    acc;
		symbolT sym;
		for (int h = 0; h < 2; h++) begin
			for (int l = 0; l < lanes; l++) begin
				centre = centreBase + l;
				for (int s = 0; s < seqLen; s++) begin
					pos = centre + s;
					acc = '0;
					for (int k = 0; k < estDepth; k++) begin
						sym = (pos - k == centre) ? symbolT'(2 * h - 1) : winSym[pos - k];
						acc = acc + sym * tapExt[k];
					end
					hypNext[h][l][s] = saturate(acc);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frameValid) begin
			hypSeq <= hypNext;
			for (int l = 0; l < lanes; l++) begin
				centreBits[l] <= windowBits[centreBase + l];
				for (int s = 0; s < seqLen; s++) begin
					rxSeq[l][s] <= windowCodes[centreBase + l + s];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			seqValid <= 1'b0;
		end else begin
			seqValid <= frameValid;
		end
	end

endmodule

// File: design/mlsdDecision.sv
`include "mlsd_config.svh"

module mlsdDecision (
	input  logic               clk,
	input  logic               arstN,
	input  logic               seqValid,
	input  mlsdTypesPkg::codeT hypSeq [2][`MLSD_LANES][`MLSD_SEQ_LENGTH],
	input  mlsdTypesPkg::codeT rxSeq [`MLSD_LANES][`MLSD_SEQ_LENGTH],
	input  logic               centreBits [`MLSD_LANES],
	output logic               predictBits [`MLSD_LANES],
	output logic               outValid
);

	import mlsdTypesPkg::*;

	localparam int lanes  = `MLSD_LANES;
	localparam int seqLen = `MLSD_SEQ_LENGTH;

	// One bit wider than a code so the difference cannot overflow.
	typedef logic signed [`MLSD_CODE_WIDTH:0] diffT;

	metricT metric [2][lanes];
	logic   bitNext [lanes];

	// ##########################################################
	// Error metrics and choice
	// ##########################################################

	always_comb begin : errorMetrics
		diffT diff;
		for (int h = 0; h < 2; h++) begin
			for (int l = 0; l < lanes; l++) begin
				metric[h][l] = '0;
				for (int s = 0; s < seqLen; s++) begin
					diff = diffT'(hypSeq[h][l][s]) - diffT'(rxSeq[l][s]);
					metric[h][l] = metric[h][l] + (diff < 0 ? metricT'(-diff) : metricT'(diff));
				end
			end
		end
	end

	// A tie means the sequences carry no information, so the slicer stands.
	always_comb begin
		for (int l = 0; l < lanes; l++) begin
			if (metric[1][l] < metric[0][l]) begin
				bitNext[l] = 1'b1;
			end else if (metric[0][l] < metric[1][l]) begin
				bitNext[l] = 1'b0;
			end else begin
				bitNext[l] = centreBits[l];
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
			for (int l = 0; l < lanes; l++) begin
				predictBits[l] <= 1'b0;
			end
		end else begin
			outValid <= seqValid;
			if (seqValid) begin
				predictBits <= bitNext;
			end
		end
	end

endmodule

// File: design/flatMlsd.sv
`include "mlsd_config.svh"

module flatMlsd (
	input  logic                clk,
	input  logic                arstN,
	input  logic                tapWrite,
	input  mlsdTapPkg::tapAddrT tapAddr,
	input  mlsdTypesPkg::tapT   tapData,
	input  logic                inValid,
	input  mlsdTypesPkg::codeT  codes [`MLSD_LANES],
	input  logic                estimateBits [`MLSD_LANES],
	output logic                predictBits [`MLSD_LANES],
	output logic                outValid
);

	import mlsdTypesPkg::*;
	import mlsdTapPkg::*;

	tapT  taps [tapCount];
	codeT windowCodes [`MLSD_FRAME_DEPTH * `MLSD_LANES];
	logic windowBits [`MLSD_FRAME_DEPTH * `MLSD_LANES];
	logic frameValid;
	codeT hypSeq [2][`MLSD_LANES][`MLSD_SEQ_LENGTH];
	codeT rxSeq [`MLSD_LANES][`MLSD_SEQ_LENGTH];
	logic centreBits [`MLSD_LANES];
	logic seqValid;

	mlsdTapStore tapStore (
		.clk      (clk),
		.arstN    (arstN),
		.tapWrite (tapWrite),
		.tapAddr  (tapAddr),
		.tapData  (tapData),
		.taps     (taps)
	);

	// Three pipeline stages follow, each adding one cycle.
	mlsdFrameBuffer frameBuffer (
		.clk          (clk),
		.arstN        (arstN),
		.inValid      (inValid),
		.codes        (codes),
		.estimateBits (estimateBits),
		.windowCodes  (windowCodes),
		.windowBits   (windowBits),
		.frameValid   (frameValid)
	);

	mlsdSeqEstimator seqEstimator (
		.clk         (clk),
		.arstN       (arstN),
		.frameValid  (frameValid),
		.windowCodes (windowCodes),
		.windowBits  (windowBits),
		.taps        (taps),
		.hypSeq      (hypSeq),
		.rxSeq       (rxSeq),
		.centreBits  (centreBits),
		.seqValid    (seqValid)
	);

	mlsdDecision decision (
		.clk         (clk),
		.arstN       (arstN),
		.seqValid    (seqValid),
		.hypSeq      (hypSeq),
		.rxSeq       (rxSeq),
		.centreBits  (centreBits),
		.predictBits (predictBits),
		.outValid    (outValid)
	);

endmodule

// File: tb/flatMlsdTb.sv
`include "mlsd_config.svh"

module flatMlsdTb;

	timeunit 1ns;
	timeprecision 100ps;

	import mlsdTypesPkg::*;
	import mlsdTapPkg::*;

	localparam int lanes      = `MLSD_LANES;
	localparam int estDepth   = `MLSD_EST_DEPTH;
	localparam int seqLen     = `MLSD_SEQ_LENGTH;
	localparam int latency    = 3;
	localparam int drainLimit = 20;
	localparam int codeMax    = (1 << (`MLSD_CODE_WIDTH - 1)) - 1;
	localparam int codeMin    = -(1 << (`MLSD_CODE_WIDTH - 1));

	// Extra rule applied to the expected bits of each frame.
	localparam int checkClean   = 1;
	localparam int checkFlipped = 2;
	localparam int checkTie     = 3;

	logic    clk;
	logic    arstN;
	logic    tapWrite;
	tapAddrT tapAddr;
	tapT     tapData;
	logic    inValid;
	codeT    codes [lanes];
	logic    estimateBits [lanes];
	logic    predictBits [lanes];
	logic    outValid;

	logic [31:0]      lfsrState;
	int               cycle;
	int               frameCount;
	int               epochFrame;
	int               refTaps [estDepth];
	bit               trueHist [$];
	bit               slicerHist [$];
	int               codeHist [$];
	int               flipHist [$];
	int               dueQ [$];
	logic [lanes-1:0] expectQ [$];

	flatMlsd UUT (
		.clk          (clk),
		.arstN        (arstN),
		.tapWrite     (tapWrite),
		.tapAddr      (tapAddr),
		.tapData      (tapData),
		.inValid      (inValid),
		.codes        (codes),
		.estimateBits (estimateBits),
		.predictBits  (predictBits),
		.outValid     (outValid)
	);

	always #5 clk = ~clk;

	// ##########################################################
	// Helpers and reference model
	// ##########################################################

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic bit randomBit();
		lfsrState = lfsrNext(lfsrState);
		return lfsrState[0];
	endfunction

	function automatic int clampCode(input int value);
		if (value > codeMax) begin
			return codeMax;
		end
		return (value < codeMin) ? codeMin : value;
	endfunction

	function automatic logic [lanes-1:0] packedPredict();
		logic [lanes-1:0] result;
		for (int l = 0; l < lanes; l++) begin
			result[l] = predictBits[l];
		end
		return result;
	endfunction

	// Decides every lane of frame f by flipping one symbol at a time.
	function automatic logic [lanes-1:0] modelDecision(input int f);
		logic [lanes-1:0] result;
		int               centre;
		int               acc;
		int               sym;
		int               diff;
		int               metric [2];
		for (int l = 0; l < lanes; l++) begin
			centre = f * lanes + l;
			for (int h = 0; h < 2; h++) begin
				metric[h] = 0;
				for (int s = 0; s < seqLen; s++) begin
					acc = 0;
					for (int k = 0; k < estDepth; k++) begin
						sym = slicerHist[centre + s - k] ? 1 : -1;
						if (s == k) begin
							sym = 2 * h - 1;
						end
						acc += refTaps[k] * sym;
					end
					diff = clampCode(acc) - codeHist[centre + s];
					metric[h] += (diff < 0) ? -diff : diff;
				end
			end
			if (metric[1] < metric[0]) begin
				result[l] = 1'b1;
			end else if (metric[0] < metric[1]) begin
				result[l] = 1'b0;
			end else begin
				result[l] = slicerHist[centre];
			end
		end
		return result;
	endfunction

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	// One clock, then compare outValid and predictBits with the schedule.
	task automatic tick();
		@(posedge clk);
		#1;
		cycle++;
		if (dueQ.size() > 0 && dueQ[0] == cycle) begin
			assert (outValid === 1'b1) else begin
				$display("FAIL outValid: got 0x%h expected 0x1 in cycle %0d", outValid, cycle);
				abortRun();
			end
			assert (packedPredict() === expectQ[0]) else begin
				$display("FAIL predictBits: got 0x%h expected 0x%h in cycle %0d",
					packedPredict(), expectQ[0], cycle);
				abortRun();
			end
			void'(dueQ.pop_front());
			void'(expectQ.pop_front());
		end else begin
			assert (outValid === 1'b0) else begin
				$display("FAIL outValid: got 0x%h expected 0x0 in cycle %0d", outValid, cycle);
				abortRun();
			end
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (dueQ.size() > 0) begin
			assert (waited < drainLimit) else begin
				$display("Timed out waiting for outValid, %0d results still due.", dueQ.size());
				abortRun();
			end
			tick();
			waited++;
		end
	endtask

	task automatic writeTap(input int addr, input int value);
		tapWrite = 1'b1;
		tapAddr  = tapAddrT'(addr);
		tapData  = tapT'(value);
		tick();
		tapWrite = 1'b0;
		refTaps[addr] = value;
	endtask

	task automatic loadTaps(input int t0, input int t1, input int t2, input int t3);
		writeTap(0, t0);
		writeTap(1, t1);
		writeTap(2, t2);
		writeTap(3, t3);
		epochFrame = frameCount;
	endtask

	// Random true bits, noiseless codes and a slicer with at most one bit flipped.
	task automatic sendFrame(input int flipLane, input int mode, input int gap);
		int               base;
		int               acc;
		int               cf;
		logic [lanes-1:0] expected;
		base = frameCount * lanes;
		for (int l = 0; l < lanes; l++) begin
			trueHist.push_back(randomBit());
			slicerHist.push_back(trueHist[base + l] ^ (l == flipLane));
			acc = 0;
			for (int k = 0; k < estDepth; k++) begin
				if (base + l - k >= 0) begin
					acc += refTaps[k] * (trueHist[base + l - k] ? 1 : -1);
				end else begin
					acc -= refTaps[k];
				end
			end
			codeHist.push_back(clampCode(acc));
			codes[l]        = codeT'(codeHist[base + l]);
			estimateBits[l] = slicerHist[base + l];
		end
		flipHist.push_back(flipLane);
		frameCount++;
		if (frameCount >= `MLSD_FRAME_DEPTH) begin
			cf       = frameCount - 1 - `MLSD_FUTURE_FRAMES;
			expected = modelDecision(cf);
			for (int l = 0; l < lanes; l++) begin
				// The true bit is only certain when the past frame holds no slicer error.
				if ((mode == checkClean && cf >= epochFrame && flipHist[cf - 1] < 0)
						|| (mode == checkFlipped && cf >= epochFrame && l == flipHist[cf])) begin
					assert (expected[l] === trueHist[cf * lanes + l]) else begin
						$display("The model missed the true bit of lane %0d in frame %0d.", l, cf);
						abortRun();
					end
				end
				if (mode == checkTie) begin
					expected[l] = slicerHist[cf * lanes + l];
				end
			end
			dueQ.push_back(cycle + latency);
			expectQ.push_back(expected);
		end
		inValid = 1'b1;
		tick();
		inValid = 1'b0;
		repeat (gap) tick();
	endtask

	// ##########################################################
	// Directed tests
	// ##########################################################

	task automatic resetAndFill();
		loadTaps(3, 2, 1, 1);
		for (int n = 0; n < 3; n++) begin
			sendFrame(-1, checkClean, 4);
		end
		drain();
	endtask

	task automatic cleanChannel();
		for (int n = 0; n < 20; n++) begin
			sendFrame(-1, checkClean, 0);
		end
		drain();
	endtask

	// Lanes 2 to 5 keep any two flips far enough apart to be judged alone.
	task automatic slicerCorrection();
		int lane;
		for (int n = 0; n < 20; n++) begin
			lane = 2 + 2 * randomBit() + randomBit();
			sendFrame(lane, checkFlipped, 0);
		end
		drain();
	endtask

	task automatic tieRule();
		int lane;
		loadTaps(0, 0, 0, 0);
		for (int n = 0; n < 12; n++) begin
			lane = 4 * randomBit() + 2 * randomBit() + randomBit();
			sendFrame(lane, checkTie, 0);
		end
		drain();
	endtask

	task automatic tapRewrite();
		loadTaps(3, 2, 1, 1);
		for (int n = 0; n < 6; n++) begin
			sendFrame(-1, checkClean, 0);
		end
		drain();
		loadTaps(4, -1, 2, -1);
		for (int n = 0; n < 16; n++) begin
			sendFrame(-1, checkClean, 0);
		end
		drain();
	endtask

	task automatic gappedStrobes();
		for (int n = 0; n < 10; n++) begin
			sendFrame(-1, checkClean, 1 + 2 * randomBit() + randomBit());
		end
		drain();
	endtask

	initial begin
		clk        = 1'b0;
		arstN      = 1'b0;
		tapWrite   = 1'b0;
		tapAddr    = '0;
		tapData    = '0;
		inValid    = 1'b0;
		lfsrState  = 32'h57ad_1326;
		cycle      = 0;
		frameCount = 0;
		epochFrame = 0;
		for (int l = 0; l < lanes; l++) begin
			codes[l]        = '0;
			estimateBits[l] = 1'b0;
		end
		for (int k = 0; k < estDepth; k++) begin
			refTaps[k] = 0;
		end
		repeat (5) @(posedge clk);
		#1;
		arstN = 1'b1;
		assert (outValid === 1'b0) else begin
			$display("FAIL outValid: got 0x%h expected 0x0 after reset", outValid);
			abortRun();
		end
		assert (packedPredict() === '0) else begin
			$display("FAIL predictBits: got 0x%h expected 0x00 after reset", packedPredict());
			abortRun();
		end
		resetAndFill();
		cleanChannel();
		slicerCorrection();
		tieRule();
		tapRewrite();
		gappedStrobes();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: src.f
+incdir+include
design/mlsdTypesPkg.sv
design/mlsdTapPkg.sv
design/mlsdTapStore.sv
design/mlsdFrameBuffer.sv
design/mlsdSeqEstimator.sv
design/mlsdDecision.sv
design/flatMlsd.sv
tb/flatMlsdTb.sv

// File: Makefile
TOP = flatMlsdTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
